//--- list.f
source/tap_types_pkg.sv
source/tap_ctrl_pkg.sv
source/cmd_decode.sv
source/cyclic_shift_reg.sv
source/mac_execute.sv
source/result_round.sv
source/tap_filter_top.sv
tests/tb_clock.sv
tests/tap_filter_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the tap filter testbench with Verilator from the project root.
rm -rf obj_dir sim.log build.log
verilator --binary --timing --timescale 1ns/10ps --top-module tap_filter_tb \
  -f list.f -Mdir obj_dir > build.log 2>&1 \
  && ./obj_dir/Vtap_filter_tb > sim.log 2>&1
grep -qx "Simulation PASSED" sim.log \
  && echo "tap filter run ok" \
  || { tail -n 30 build.log sim.log 2>/dev/null; exit 1; }

//--- tests/tap_filter_tb.sv
`timescale 1ns/10ps

module tap_filter_tb;

  import tap_types_pkg::*;
  import tap_ctrl_pkg::*;

  typedef struct packed {
    result_t value;
    int      cycle;                                     // Cycle where result_valid is due.
  } expect_t;

  logic clk, rst_n, cmd_valid, pix_valid, result_valid;
  cmd_t       cmd;
  load_word_t load_data;
  pixel_t     pixel;
  result_t    result;

  logic [31:0] lcg_state = 32'hfdab;
  int          cycle_count = 0;
  expect_t     exp_q[$];
  weight_t     model_regs [R_DEPTH];                    // Mirror of the weight register.
  int          model_waddr, model_last_tap, model_last_word, model_taps;
  acc_t        model_sum;

  tb_clock u_clock (.clk(clk));

  tap_filter_top u_tap_filter_top (
    .clk(clk), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd(cmd), .load_data(load_data),
    .pix_valid(pix_valid), .pixel(pixel), .result_valid(result_valid), .result(result)
  );

  always @(posedge clk) cycle_count <= cycle_count + 1;

  // --------------------
  // Error handling
  // --------------------
  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic report_error(string msg);
    $display("%0t: %s", $time, msg);
    abort_run();
  endtask

  task automatic check_result(result_t got, result_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t: result %0d, expected %0d", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_latency(int got, int exp);
    if (got != exp) begin
      $display("[FAIL] %0t: result in cycle %0d, expected in cycle %0d", $time, got, exp);
      abort_run();
    end
  endtask

  // --------------------
  // Reference model
  // --------------------
  function automatic result_t round_sat(acc_t sum);
    longint wide;
    wide = (longint'(sum) + (longint'(1) <<< (ROUND_SHIFT - 1))) >>> ROUND_SHIFT;
    if (wide > 32767) return 16'sh7fff;
    if (wide < -32768) return 16'sh8000;
    return result_t'(wide);
  endfunction

  task automatic model_command(cmd_t c, load_word_t lw);
    if (c.op == OP_SET_TAPS) begin
      model_last_tap  = int'(c.arg);
      model_last_word = model_last_tap / RATIO;
      model_waddr     = 0;
    end else if (c.op == OP_LOAD) begin
      for (int k = 0; k < RATIO; k++) model_regs[model_waddr * RATIO + k] = lw[k];
      model_waddr = (model_waddr == model_last_word) ? 0 : model_waddr + 1;
    end
  endtask

  task automatic model_pixel(pixel_t p);
    weight_t rotated [R_DEPTH];
    expect_t e;
    model_sum = model_sum + acc_t'(int'(p) * int'(model_regs[0]));
    for (int r = 0; r < R_DEPTH; r++) begin
      rotated[r] = (r == model_last_tap) ? model_regs[0] : model_regs[(r + 1) % R_DEPTH];
    end
    model_regs = rotated;
    if (model_taps == model_last_tap) begin
      e.value = round_sat(model_sum);
      e.cycle = cycle_count + 2;                        // Result two cycles after the last pixel.
      exp_q.push_back(e);
      model_sum  = 0;
      model_taps = 0;
    end else begin
      model_taps++;
    end
  endtask

  // Inputs and outputs are sampled on the falling edge, away from the drive edge.
  always @(negedge clk) begin
    expect_t e;
    if (rst_n !== 1'b1) begin
      foreach (model_regs[r]) model_regs[r] = '0;
      {model_waddr, model_last_tap, model_last_word, model_taps} = '0;
      model_sum = '0;
    end else begin
      if (result_valid === 1'b1) begin
        if (exp_q.size() == 0) report_error("result_valid pulsed with no window outstanding");
        else begin
          e = exp_q.pop_front();
          check_result(result, e.value);
          check_latency(cycle_count, e.cycle);
        end
      end
      if (cmd_valid === 1'b1) model_command(cmd, load_data);
      if (pix_valid === 1'b1) model_pixel(pixel);
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic send_cmd(opcode_t op, logic [TAP_ADDR_W-1:0] arg, load_word_t data);
    cmd_t c;
    c.op  = op;
    c.arg = arg;
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd       <= c;
    load_data <= data;
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic load_words(int count, bit fill, weight_t w);
    load_word_t lw;
    logic [31:0] r;
    repeat (count) begin
      for (int k = 0; k < RATIO; k++) begin
        r = next_random();
        lw[k] = fill ? w : weight_t'(r[31:16]);
      end
      send_cmd(OP_LOAD, '0, lw);
    end
  endtask

  task automatic drive_pixel(pixel_t p, int gap);
    @(posedge clk);
    pix_valid <= 1'b1;
    pixel     <= p;
    repeat (gap) begin
      @(posedge clk);
      pix_valid <= 1'b0;
    end
  endtask

  task automatic drive_pixels(int count, int max_gap, bit fixed, pixel_t value);
    logic [31:0] r;
    for (int i = 0; i < count; i++) begin
      r = next_random();
      drive_pixel(fixed ? value : pixel_t'(r[23:16]), int'(r[11:8]) % (max_gap + 1));
    end
    @(posedge clk);
    pix_valid <= 1'b0;
  endtask

  task automatic wait_drained(int limit);
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited >= limit) report_error("timeout while waiting for result_valid");
      else begin
        @(posedge clk);
        waited++;
      end
    end
  endtask

  initial begin
    logic [31:0] r;
    int          taps;
    load_word_t  lw;
    rst_n = 1'b0;
    cmd_valid = 1'b0;
    cmd = '0;
    load_data = '0;
    pix_valid = 1'b0;
    pixel = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    repeat (20) @(posedge clk);                         // Quiet after reset.
    drive_pixels(6, 2, 1'b0, '0);                       // One-tap windows, zero weights.
    wait_drained(20);
    send_cmd(OP_SET_TAPS, 4'd15, '0);
    load_words(W_DEPTH, 1'b0, '0);
    drive_pixels(16, 2, 1'b0, '0);
    wait_drained(20);
    drive_pixels(4 * 16, 0, 1'b0, '0);                  // Back to back windows.
    wait_drained(20);
    load_words(W_DEPTH, 1'b1, 16'sh7fff);
    drive_pixels(16, 0, 1'b1, 8'sh7f);
    drive_pixels(16, 0, 1'b1, 8'sh80);
    load_words(W_DEPTH, 1'b1, 16'sh8000);
    drive_pixels(16, 1, 1'b1, 8'sh80);
    wait_drained(40);
    // Single tap with weight 2 puts results on half steps.
    send_cmd(OP_SET_TAPS, 4'd0, '0);
    lw = '0;
    lw[0] = 16'sd2;
    send_cmd(OP_LOAD, '0, lw);
    drive_pixel(8'sd64, 1);
    drive_pixel(-8'sd64, 0);
    drive_pixel(8'sd63, 2);
    drive_pixels(1, 0, 1'b1, -8'sd65);
    wait_drained(20);
    repeat (6) begin
      r = next_random();
      taps = int'(r[19:16]) + 1;
      // Leave the write address on word 1 so the reconfiguration has to restart it.
      send_cmd(OP_SET_TAPS, 4'd15, '0);
      load_words(1, 1'b0, '0);
      send_cmd(OP_SET_TAPS, TAP_ADDR_W'(taps - 1), '0);
      load_words((taps - 1) / RATIO + 1, 1'b0, '0);
      drive_pixels(taps * 3, 3, 1'b0, '0);
      wait_drained(40);
    end
    repeat (10) @(posedge clk);
    if (exp_q.size() != 0) begin
      report_error("expected results were never produced");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
  output logic clk
);

  localparam int HALF_PERIOD = 5;                       // 10 ns period.

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

endmodule

//--- source/tap_filter_top.sv
`timescale 1ns/10ps

module tap_filter_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cmd_valid,
  input  tap_ctrl_pkg::cmd_t        cmd,
  input  tap_types_pkg::load_word_t load_data,
  input  logic                      pix_valid,
  input  tap_types_pkg::pixel_t     pixel,
  output logic                      result_valid,
  output tap_types_pkg::result_t    result
);

  import tap_types_pkg::*;
  import tap_ctrl_pkg::*;

  tap_cfg_t   cfg;
  logic       w_en;
  logic       w_restart;
  load_word_t load_word;
  logic       r_en;
  weight_t    head;
  logic       acc_valid;
  acc_t       acc;

  // --------------------
  // Control path
  // --------------------
  cmd_decode u_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cfg       (cfg),
    .w_en      (w_en),
    .w_restart (w_restart),
    .load_out  (load_word),
    .load_data (load_data)
  );

  cyclic_shift_reg u_weights (
    .clk       (clk),
    .rst_n     (rst_n),
    .w_en      (w_en),
    .w_restart (w_restart),
    .r_en      (r_en),
    .load_in   (load_word),
    .cfg       (cfg),
    .head      (head)
  );

  // --------------------
  // Data path
  // --------------------
  mac_execute u_execute (
    .clk       (clk),
    .rst_n     (rst_n),
    .pix_valid (pix_valid),
    .pixel     (pixel),
    .head      (head),
    .cfg       (cfg),
    .r_en      (r_en),
    .acc_valid (acc_valid),
    .acc       (acc)
  );

  result_round u_result (
    .clk          (clk),
    .rst_n        (rst_n),
    .acc_valid    (acc_valid),
    .acc          (acc),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

//--- source/result_round.sv
`timescale 1ns/10ps

module result_round (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   acc_valid,
  input  tap_types_pkg::acc_t    acc,
  output logic                   result_valid,
  output tap_types_pkg::result_t result
);

  import tap_types_pkg::*;

  acc_t    biased;
  acc_t    shifted;
  result_t clamped;

  // Round half up, then drop the fraction bits.
  assign biased  = acc + ROUND_HALF;
  assign shifted = biased >>> ROUND_SHIFT;

  // --------------------
  // Saturation
  // --------------------
  always_comb begin
    if (shifted > RESULT_MAX) begin
      clamped = result_t'(RESULT_MAX);
    end else if (shifted < RESULT_MIN) begin
      clamped = result_t'(RESULT_MIN);
    end else begin
      clamped = result_t'(shifted);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= acc_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (acc_valid) begin
      result <= clamped;
    end
  end

endmodule

//--- source/mac_execute.sv
`timescale 1ns/10ps

module mac_execute (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   pix_valid,
  input  tap_types_pkg::pixel_t  pixel,
  input  tap_types_pkg::weight_t head,
  input  tap_ctrl_pkg::tap_cfg_t cfg,
  output logic                   r_en,
  output logic                   acc_valid,
  output tap_types_pkg::acc_t    acc
);

  import tap_types_pkg::*;

  logic [TAP_ADDR_W-1:0] tap_cnt;
  acc_t                  sum;
  acc_t                  product;
  acc_t                  sum_next;
  logic                  last_pix;

  assign r_en     = pix_valid;                          // One rotation per pixel.
  assign product  = acc_t'(pixel) * acc_t'(head);
  assign sum_next = sum + product;
  assign last_pix = pix_valid && (tap_cnt == cfg.last_tap);

  // --------------------
  // Tap counter and sum
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tap_cnt   <= '0;
      sum       <= '0;
      acc_valid <= 1'b0;
    end else begin
      acc_valid <= last_pix;
      if (last_pix) begin
        tap_cnt <= '0;
        sum     <= '0;                                  // Next window starts clean.
      end else if (pix_valid) begin
        tap_cnt <= tap_cnt + 1'b1;
        sum     <= sum_next;
      end
    end
  end

  // Window total, including the closing product.
  always_ff @(posedge clk) begin
    if (last_pix) begin
      acc <= sum_next;
    end
  end

endmodule

//--- source/cyclic_shift_reg.sv
`timescale 1ns/10ps

module cyclic_shift_reg (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      w_en,
  input  logic                      w_restart,
  input  logic                      r_en,
  input  tap_types_pkg::load_word_t load_in,
  input  tap_ctrl_pkg::tap_cfg_t    cfg,
  output tap_types_pkg::weight_t    head
);

  import tap_types_pkg::*;

  weight_t [R_DEPTH-1:0]  regs;
  weight_t [R_DEPTH-1:0]  rot_next;
  logic    [R_DEPTH-1:0]  w_sel;
  logic [WORD_ADDR_W-1:0] w_addr;

  // --------------------
  // Write word address
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_addr <= '0;
    end else if (w_restart) begin
      w_addr <= '0;
    end else if (w_en) begin
      w_addr <= (w_addr == cfg.last_word) ? '0 : w_addr + 1'b1;
    end
  end

  // --------------------
  // Select and rotate
  // --------------------
  always_comb begin
    for (int r = 0; r < R_DEPTH; r++) begin
      w_sel[r] = w_en && (w_addr == WORD_ADDR_W'(r / RATIO));
      // The last active tap closes the ring back to the head.
      if (TAP_ADDR_W'(r) == cfg.last_tap) begin
        rot_next[r] = regs[0];
      end else begin
        rot_next[r] = regs[(r + 1) % R_DEPTH];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regs <= '0;
    end else begin
      for (int r = 0; r < R_DEPTH; r++) begin
        if (w_sel[r]) begin
          regs[r] <= load_in[r % RATIO];                // Write wins over rotate.
        end else if (r_en) begin
          regs[r] <= rot_next[r];
        end
      end
    end
  end

  assign head = regs[0];

endmodule

//--- source/cmd_decode.sv
`timescale 1ns/10ps

module cmd_decode (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cmd_valid,
  input  tap_ctrl_pkg::cmd_t        cmd,
  output tap_ctrl_pkg::tap_cfg_t    cfg,
  output logic                      w_en,
  output logic                      w_restart,
  output tap_types_pkg::load_word_t load_out,
  input  tap_types_pkg::load_word_t load_data
);

  import tap_types_pkg::*;
  import tap_ctrl_pkg::*;

  logic set_taps;
  logic load_word;

  assign set_taps  = cmd_valid && (cmd.op == OP_SET_TAPS);
  assign load_word = cmd_valid && (cmd.op == OP_LOAD);

  // --------------------
  // Configuration and strobes
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg       <= '0;                             // One tap, one word.
      w_en      <= 1'b0;
      w_restart <= 1'b0;
    end else begin
      w_en      <= load_word;
      w_restart <= set_taps;
      if (set_taps) begin
        cfg.last_tap  <= cmd.arg;
        cfg.last_word <= WORD_ADDR_W'(cmd.arg / RATIO);
      end
    end
  end

  // Load word rides along with w_en.
  always_ff @(posedge clk) begin
    if (load_word) begin
      load_out <= load_data;
    end
  end

endmodule

//--- source/tap_ctrl_pkg.sv
package tap_ctrl_pkg;

  // --------------------
  // Commands
  // --------------------
  typedef enum logic [1:0] {
    OP_NOP      = 2'd0,
    OP_SET_TAPS = 2'd1,
    OP_LOAD     = 2'd2
  } opcode_t;

  typedef struct packed {
    opcode_t                               op;
    logic [tap_types_pkg::TAP_ADDR_W-1:0] arg;   // Tap count minus one.
  } cmd_t;

  // --------------------
  // Configuration
  // --------------------
  typedef struct packed {
    logic [tap_types_pkg::TAP_ADDR_W-1:0]  last_tap;
    logic [tap_types_pkg::WORD_ADDR_W-1:0] last_word;
  } tap_cfg_t;

endpackage

//--- source/tap_types_pkg.sv
package tap_types_pkg;

  // --------------------
  // Geometry
  // --------------------
  localparam int R_DEPTH     = 16;                  // Weight registers.
  localparam int RATIO       = 4;                   // Weights per load word.
  localparam int W_DEPTH     = R_DEPTH / RATIO;     // Load words per full register.
  localparam int TAP_ADDR_W  = $clog2(R_DEPTH);
  localparam int WORD_ADDR_W = $clog2(W_DEPTH);

  // --------------------
  // Data types
  // --------------------
  typedef logic signed [15:0] weight_t;
  typedef logic signed [7:0]  pixel_t;
  typedef logic signed [31:0] acc_t;
  typedef logic signed [15:0] result_t;

  // Element 0 lands in the lowest tap of the addressed word.
  typedef weight_t [RATIO-1:0] load_word_t;

  // --------------------
  // Rounding
  // --------------------
  localparam int ROUND_SHIFT = 8;

  // Half an output LSB, added before the shift.
  localparam acc_t ROUND_HALF = 32'sd1 <<< (ROUND_SHIFT - 1);

  localparam acc_t RESULT_MAX = 32'sd32767;         // Largest result_t.
  localparam acc_t RESULT_MIN = -32'sd32768;        // Smallest result_t.

endpackage
